// ==== Makefile ====
VERILATOR   = verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing
TOP         = tb_axi_bridge
FILELIST    = axi_bridge_top.f
OBJ_DIR     = obj_dir
PASS_TEXT   = Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== axi_bridge_top.f ====
design/mem_bridge_pkg.sv
design/read_arbiter.sv
design/write_buffer.sv
design/axi_write_engine.sv
design/perf_counter.sv
design/axi_bridge_top.sv
sim/axi_slave_model.sv
sim/tb_axi_bridge.sv

// ==== design/axi_bridge_top.sv ====
`timescale 1ns/1ns

module axi_bridge_top #(
  parameter int WBUF_DEPTH = 4,
  parameter int CNT_W      = 32
) (
  input  logic                                 aclk,
  input  logic                                 i_rst,
  // instruction read port
  input  logic                                 i_inst_rd_req,
  input  mem_bridge_pkg::rd_type_t             i_inst_rd_type,
  input  logic [mem_bridge_pkg::ADDR_W-1:0]    i_inst_rd_addr,
  output logic                                 o_inst_rd_rdy,
  output logic                                 o_inst_ret_valid,
  output logic                                 o_inst_ret_last,
  output logic [mem_bridge_pkg::DATA_W-1:0]    o_inst_ret_data,
  // data read port
  input  logic                                 i_data_rd_req,
  input  mem_bridge_pkg::rd_type_t             i_data_rd_type,
  input  logic [mem_bridge_pkg::ADDR_W-1:0]    i_data_rd_addr,
  output logic                                 o_data_rd_rdy,
  output logic                                 o_data_ret_valid,
  output logic                                 o_data_ret_last,
  output logic [mem_bridge_pkg::DATA_W-1:0]    o_data_ret_data,
  // data write port
  input  logic                                 i_data_wr_req,
  input  mem_bridge_pkg::wr_type_t             i_data_wr_type,
  input  logic [mem_bridge_pkg::ADDR_W-1:0]    i_data_wr_addr,
  input  mem_bridge_pkg::strb_t                i_data_wr_strb,
  input  logic [mem_bridge_pkg::LINE_W-1:0]    i_data_wr_data,
  output logic                                 o_data_wr_rdy,
  // AXI read address
  output mem_bridge_pkg::axi_id_t              o_arid,
  output logic [mem_bridge_pkg::ADDR_W-1:0]    o_araddr,
  output logic [mem_bridge_pkg::LEN_W-1:0]     o_arlen,
  output logic                                 o_arvalid,
  input  logic                                 i_arready,
  // AXI read data
  input  mem_bridge_pkg::axi_id_t              i_rid,
  input  logic [mem_bridge_pkg::DATA_W-1:0]    i_rdata,
  input  logic                                 i_rlast,
  input  logic                                 i_rvalid,
  // AXI write address
  output mem_bridge_pkg::axi_id_t              o_awid,
  output logic [mem_bridge_pkg::ADDR_W-1:0]    o_awaddr,
  output logic [mem_bridge_pkg::LEN_W-1:0]     o_awlen,
  output logic                                 o_awvalid,
  input  logic                                 i_awready,
  // AXI write data and response
  output logic [mem_bridge_pkg::DATA_W-1:0]    o_wdata,
  output mem_bridge_pkg::strb_t                o_wstrb,
  output logic                                 o_wlast,
  output logic                                 o_wvalid,
  input  logic                                 i_wready,
  input  logic                                 i_bvalid,
  // performance
  output logic [CNT_W-1:0]                     o_inst_reads,
  output logic [CNT_W-1:0]                     o_data_reads,
  output logic [CNT_W-1:0]                     o_data_writes
);
  import mem_bridge_pkg::*;

  logic                wbuf_empty;
  logic                wbuf_pop;
  logic                head_valid;
  wr_type_t            head_type;
  logic [ADDR_W-1:0]   head_addr;
  strb_t               head_strb;
  logic [LINE_W-1:0]   head_data;

  read_arbiter read_arbiter_inst (
    .aclk             (aclk),
    .i_rst            (i_rst),
    .i_inst_rd_req    (i_inst_rd_req),
    .i_inst_rd_type   (i_inst_rd_type),
    .i_inst_rd_addr   (i_inst_rd_addr),
    .o_inst_rd_rdy    (o_inst_rd_rdy),
    .o_inst_ret_valid (o_inst_ret_valid),
    .o_inst_ret_last  (o_inst_ret_last),
    .o_inst_ret_data  (o_inst_ret_data),
    .i_data_rd_req    (i_data_rd_req),
    .i_data_rd_type   (i_data_rd_type),
    .i_data_rd_addr   (i_data_rd_addr),
    .o_data_rd_rdy    (o_data_rd_rdy),
    .o_data_ret_valid (o_data_ret_valid),
    .o_data_ret_last  (o_data_ret_last),
    .o_data_ret_data  (o_data_ret_data),
    .i_wbuf_empty     (wbuf_empty),
    .o_arid           (o_arid),
    .o_araddr         (o_araddr),
    .o_arlen          (o_arlen),
    .o_arvalid        (o_arvalid),
    .i_arready        (i_arready),
    .i_rid            (i_rid),
    .i_rdata          (i_rdata),
    .i_rlast          (i_rlast),
    .i_rvalid         (i_rvalid)
  );

  write_buffer #(
    .WBUF_DEPTH (WBUF_DEPTH)
  ) write_buffer_inst (
    .aclk         (aclk),
    .i_rst        (i_rst),
    .i_wr_req     (i_data_wr_req),
    .i_wr_type    (i_data_wr_type),
    .i_wr_addr    (i_data_wr_addr),
    .i_wr_strb    (i_data_wr_strb),
    .i_wr_data    (i_data_wr_data),
    .o_wr_rdy     (o_data_wr_rdy),
    .o_head_valid (head_valid),
    .o_head_type  (head_type),
    .o_head_addr  (head_addr),
    .o_head_strb  (head_strb),
    .o_head_data  (head_data),
    .i_pop        (wbuf_pop),
    .o_empty      (wbuf_empty)
  );

  axi_write_engine axi_write_engine_inst (
    .aclk         (aclk),
    .i_rst        (i_rst),
    .i_head_valid (head_valid),
    .i_head_type  (head_type),
    .i_head_addr  (head_addr),
    .i_head_strb  (head_strb),
    .i_head_data  (head_data),
    .o_pop        (wbuf_pop),
    .o_awid       (o_awid),
    .o_awaddr     (o_awaddr),
    .o_awlen      (o_awlen),
    .o_awvalid    (o_awvalid),
    .i_awready    (i_awready),
    .o_wdata      (o_wdata),
    .o_wstrb      (o_wstrb),
    .o_wlast      (o_wlast),
    .o_wvalid     (o_wvalid),
    .i_wready     (i_wready),
    .i_bvalid     (i_bvalid)
  );

  perf_counter #(
    .CNT_W (CNT_W)
  ) perf_counter_inst (
    .aclk            (aclk),
    .i_rst           (i_rst),
    .i_inst_rd_req   (i_inst_rd_req),
    .i_inst_rd_rdy   (o_inst_rd_rdy),
    .i_data_rd_req   (i_data_rd_req),
    .i_data_rd_rdy   (o_data_rd_rdy),
    .i_data_wr_req   (i_data_wr_req),
    .i_data_wr_rdy   (o_data_wr_rdy),
    .o_inst_reads    (o_inst_reads),
    .o_data_reads    (o_data_reads),
    .o_data_writes   (o_data_writes)
  );

endmodule

// ==== design/axi_write_engine.sv ====
`timescale 1ns/1ns

module axi_write_engine (
  input  logic                                 aclk,
  input  logic                                 i_rst,
  // buffer head
  input  logic                                 i_head_valid,
  input  mem_bridge_pkg::wr_type_t             i_head_type,
  input  logic [mem_bridge_pkg::ADDR_W-1:0]    i_head_addr,
  input  mem_bridge_pkg::strb_t                i_head_strb,
  input  logic [mem_bridge_pkg::LINE_W-1:0]    i_head_data,
  output logic                                 o_pop,
  // AW channel
  output mem_bridge_pkg::axi_id_t              o_awid,
  output logic [mem_bridge_pkg::ADDR_W-1:0]    o_awaddr,
  output logic [mem_bridge_pkg::LEN_W-1:0]     o_awlen,
  output logic                                 o_awvalid,
  input  logic                                 i_awready,
  // W channel
  output logic [mem_bridge_pkg::DATA_W-1:0]    o_wdata,
  output mem_bridge_pkg::strb_t                o_wstrb,
  output logic                                 o_wlast,
  output logic                                 o_wvalid,
  input  logic                                 i_wready,
  // B channel
  input  logic                                 i_bvalid
);
  import mem_bridge_pkg::*;

  localparam int BEAT_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_RESP
  } state_t;

  state_t            state;
  logic [BEAT_W-1:0] beat;
  logic [BEAT_W-1:0] last_beat;
  logic              is_line;

  assign is_line   = (i_head_type == TYPE_LINE);
  assign last_beat = is_line ? BEAT_W'(LINE_WORDS - 1) : '0;

  // head entry stays put until its B response pops it
  assign o_awvalid = (state == ST_ADDR);
  assign o_awid    = ID_DATA;
  assign o_awaddr  = i_head_addr;
  assign o_awlen   = is_line ? LEN_W'(LINE_WORDS - 1) : '0;

  assign o_wvalid  = (state == ST_DATA);
  assign o_wdata   = i_head_data[beat*DATA_W +: DATA_W];
  assign o_wstrb   = is_line ? '1 : i_head_strb;
  assign o_wlast   = (beat == last_beat);

  assign o_pop     = (state == ST_RESP) && i_bvalid;

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      state <= ST_IDLE;
      beat  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          beat <= '0;
          if (i_head_valid) begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (i_awready) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (i_wready) begin
            if (o_wlast) begin
              state <= ST_RESP;
            end else begin
              beat <= beat + 1'b1;
            end
          end
        end
        ST_RESP: begin
          if (i_bvalid) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== design/mem_bridge_pkg.sv ====
package mem_bridge_pkg;

  // bus and line geometry
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = LINE_WORDS * DATA_W;
  localparam int LEN_W      = 8;

  // request type from the cache side
  typedef logic [2:0] rd_type_t;
  typedef logic [2:0] wr_type_t;

  // single uncached word, burst of one
  localparam logic [2:0] TYPE_WORD = 3'b010;
  // full cache line, LINE_WORDS beats
  localparam logic [2:0] TYPE_LINE = 3'b100;

  typedef logic [3:0] axi_id_t;
  typedef logic [3:0] strb_t;

  // instruction refills use id 0, data reads and all writes use id 1
  localparam axi_id_t ID_INST = 4'd0;
  localparam axi_id_t ID_DATA = 4'd1;

endpackage

// ==== design/perf_counter.sv ====
`timescale 1ns/1ns

module perf_counter #(
  parameter int CNT_W = 32
) (
  input  logic             aclk,
  input  logic             i_rst,
  input  logic             i_inst_rd_req,
  input  logic             i_inst_rd_rdy,
  input  logic             i_data_rd_req,
  input  logic             i_data_rd_rdy,
  input  logic             i_data_wr_req,
  input  logic             i_data_wr_rdy,
  output logic [CNT_W-1:0] o_inst_reads,
  output logic [CNT_W-1:0] o_data_reads,
  output logic [CNT_W-1:0] o_data_writes
);

  // one count per accepted request
  always_ff @(posedge aclk) begin
    if (i_rst) begin
      o_inst_reads  <= '0;
      o_data_reads  <= '0;
      o_data_writes <= '0;
    end else begin
      if (i_inst_rd_req && i_inst_rd_rdy) begin
        o_inst_reads <= o_inst_reads + 1'b1;
      end
      if (i_data_rd_req && i_data_rd_rdy) begin
        o_data_reads <= o_data_reads + 1'b1;
      end
      if (i_data_wr_req && i_data_wr_rdy) begin
        o_data_writes <= o_data_writes + 1'b1;
      end
    end
  end

endmodule

// ==== design/read_arbiter.sv ====
`timescale 1ns/1ns

module read_arbiter (
  input  logic                                 aclk,
  input  logic                                 i_rst,
  // instruction side
  input  logic                                 i_inst_rd_req,
  input  mem_bridge_pkg::rd_type_t             i_inst_rd_type,
  input  logic [mem_bridge_pkg::ADDR_W-1:0]    i_inst_rd_addr,
  output logic                                 o_inst_rd_rdy,
  output logic                                 o_inst_ret_valid,
  output logic                                 o_inst_ret_last,
  output logic [mem_bridge_pkg::DATA_W-1:0]    o_inst_ret_data,
  // data side
  input  logic                                 i_data_rd_req,
  input  mem_bridge_pkg::rd_type_t             i_data_rd_type,
  input  logic [mem_bridge_pkg::ADDR_W-1:0]    i_data_rd_addr,
  output logic                                 o_data_rd_rdy,
  output logic                                 o_data_ret_valid,
  output logic                                 o_data_ret_last,
  output logic [mem_bridge_pkg::DATA_W-1:0]    o_data_ret_data,
  input  logic                                 i_wbuf_empty,
  // AR channel
  output mem_bridge_pkg::axi_id_t              o_arid,
  output logic [mem_bridge_pkg::ADDR_W-1:0]    o_araddr,
  output logic [mem_bridge_pkg::LEN_W-1:0]     o_arlen,
  output logic                                 o_arvalid,
  input  logic                                 i_arready,
  // R channel
  input  mem_bridge_pkg::axi_id_t              i_rid,
  input  logic [mem_bridge_pkg::DATA_W-1:0]    i_rdata,
  input  logic                                 i_rlast,
  input  logic                                 i_rvalid
);
  import mem_bridge_pkg::*;

  logic inst_busy;
  logic data_busy;
  logic inst_elig;
  logic data_elig;
  logic ar_fire;

  function automatic logic [LEN_W-1:0] burst_len(input rd_type_t rd_type);
    logic [LEN_W-1:0] len;
    len = (rd_type == TYPE_LINE) ? LEN_W'(LINE_WORDS - 1) : '0;
    return len;
  endfunction

  // uncached words wait for the write buffer to drain
  assign inst_elig = i_inst_rd_req && !inst_busy &&
                     (i_inst_rd_type != TYPE_WORD || i_wbuf_empty);
  assign data_elig = i_data_rd_req && !data_busy &&
                     (i_data_rd_type != TYPE_WORD || i_wbuf_empty);

  assign ar_fire       = o_arvalid && i_arready;
  assign o_inst_rd_rdy = ar_fire && (o_arid == ID_INST);
  assign o_data_rd_rdy = ar_fire && (o_arid == ID_DATA);

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      o_arvalid <= 1'b0;
    end else if (!o_arvalid) begin
      o_arvalid <= data_elig || inst_elig;
    end else if (i_arready) begin
      o_arvalid <= 1'b0;
    end
  end

  // address fields, data port first
  always_ff @(posedge aclk) begin
    if (!o_arvalid) begin
      if (data_elig) begin
        o_arid   <= ID_DATA;
        o_araddr <= i_data_rd_addr;
        o_arlen  <= burst_len(i_data_rd_type);
      end else begin
        o_arid   <= ID_INST;
        o_araddr <= i_inst_rd_addr;
        o_arlen  <= burst_len(i_inst_rd_type);
      end
    end
  end

  // one outstanding read per id, released by rlast
  always_ff @(posedge aclk) begin
    if (i_rst) begin
      inst_busy <= 1'b0;
      data_busy <= 1'b0;
    end else begin
      if (o_inst_rd_rdy) begin
        inst_busy <= 1'b1;
      end else if (o_inst_ret_valid && i_rlast) begin
        inst_busy <= 1'b0;
      end
      if (o_data_rd_rdy) begin
        data_busy <= 1'b1;
      end else if (o_data_ret_valid && i_rlast) begin
        data_busy <= 1'b0;
      end
    end
  end

  assign o_inst_ret_valid = i_rvalid && (i_rid == ID_INST);
  assign o_inst_ret_last  = i_rlast;
  assign o_inst_ret_data  = i_rdata;
  assign o_data_ret_valid = i_rvalid && (i_rid == ID_DATA);
  assign o_data_ret_last  = i_rlast;
  assign o_data_ret_data  = i_rdata;

endmodule

// ==== design/write_buffer.sv ====
`timescale 1ns/1ns

module write_buffer #(
  parameter int WBUF_DEPTH = 4
) (
  input  logic                                 aclk,
  input  logic                                 i_rst,
  input  logic                                 i_wr_req,
  input  mem_bridge_pkg::wr_type_t             i_wr_type,
  input  logic [mem_bridge_pkg::ADDR_W-1:0]    i_wr_addr,
  input  mem_bridge_pkg::strb_t                i_wr_strb,
  input  logic [mem_bridge_pkg::LINE_W-1:0]    i_wr_data,
  output logic                                 o_wr_rdy,
  output logic                                 o_head_valid,
  output mem_bridge_pkg::wr_type_t             o_head_type,
  output logic [mem_bridge_pkg::ADDR_W-1:0]    o_head_addr,
  output mem_bridge_pkg::strb_t                o_head_strb,
  output logic [mem_bridge_pkg::LINE_W-1:0]    o_head_data,
  input  logic                                 i_pop,
  output logic                                 o_empty
);
  import mem_bridge_pkg::*;

  localparam int PTR_W = (WBUF_DEPTH > 1) ? $clog2(WBUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(WBUF_DEPTH + 1);

  wr_type_t          type_mem [WBUF_DEPTH];
  logic [ADDR_W-1:0] addr_mem [WBUF_DEPTH];
  strb_t             strb_mem [WBUF_DEPTH];
  logic [LINE_W-1:0] data_mem [WBUF_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;

  assign o_wr_rdy     = (count != CNT_W'(WBUF_DEPTH));
  assign o_head_valid = (count != '0);
  assign push         = i_wr_req && o_wr_rdy;
  assign pop          = i_pop && o_head_valid;

  // a write arriving this cycle already blocks uncached reads
  assign o_empty = (count == '0) && !i_wr_req;

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(WBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(WBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      type_mem[wr_ptr] <= i_wr_type;
      addr_mem[wr_ptr] <= i_wr_addr;
      strb_mem[wr_ptr] <= i_wr_strb;
      data_mem[wr_ptr] <= i_wr_data;
    end
  end

  assign o_head_type = type_mem[rd_ptr];
  assign o_head_addr = addr_mem[rd_ptr];
  assign o_head_strb = strb_mem[rd_ptr];
  assign o_head_data = data_mem[rd_ptr];

endmodule

// ==== sim/axi_slave_model.sv ====
`timescale 1ns/1ns

module axi_slave_model (
  input  logic                              aclk,
  input  logic                              i_rst,
  input  logic                              i_aw_hold,
  input  mem_bridge_pkg::axi_id_t           i_arid,
  input  logic [31:0]                       i_araddr,
  input  logic [7:0]                        i_arlen,
  input  logic                              i_arvalid,
  output logic                              o_arready,
  output mem_bridge_pkg::axi_id_t           o_rid,
  output logic [31:0]                       o_rdata,
  output logic                              o_rlast,
  output logic                              o_rvalid,
  input  logic [31:0]                       i_awaddr,
  input  logic                              i_awvalid,
  output logic                              o_awready,
  input  logic [31:0]                       i_wdata,
  input  mem_bridge_pkg::strb_t             i_wstrb,
  input  logic                              i_wlast,
  input  logic                              i_wvalid,
  output logic                              o_wready,
  output logic                              o_bvalid
);
  import mem_bridge_pkg::*;

  logic [31:0] mem [logic [31:0]];
  axi_id_t     ar_id_q [$];
  logic [31:0] ar_addr_q [$];
  int          ar_len_q [$];
  int          r_beat;
  int          w_beat;
  logic [31:0] aw_addr;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr)) return mem[addr];
    return addr ^ 32'h5a5a0000;
  endfunction

  initial begin
    {o_arready, o_awready, o_wready, o_rvalid, o_rlast, o_bvalid} = '0;
    o_rid   = '0;
    o_rdata = '0;
  end

  // random back-pressure, awready can be parked low by the testbench
  always @(posedge aclk) begin
    o_arready <= !i_rst && ($urandom % 4 != 0);
    o_awready <= !i_rst && !i_aw_hold && ($urandom % 4 != 0);
    o_wready  <= !i_rst && ($urandom % 3 != 0);
  end

  // reads are answered in order of acceptance, rready assumed high
  always @(posedge aclk) begin
    if (i_rst) begin
      o_rvalid <= 1'b0;
      r_beat = 0;
    end else begin
      if (o_rvalid) begin
        if (o_rlast) begin
          void'(ar_id_q.pop_front());
          void'(ar_addr_q.pop_front());
          void'(ar_len_q.pop_front());
          r_beat = 0;
        end else begin
          r_beat++;
        end
      end
      if (i_arvalid && o_arready) begin
        ar_id_q.push_back(i_arid);
        ar_addr_q.push_back(i_araddr);
        ar_len_q.push_back(int'(i_arlen));
      end
      o_rvalid <= (ar_id_q.size() != 0);
      if (ar_id_q.size() != 0) begin
        o_rid   <= ar_id_q[0];
        o_rdata <= read_word(ar_addr_q[0] + 32'(4 * r_beat));
        o_rlast <= (r_beat == ar_len_q[0]);
      end
    end
  end

  always @(posedge aclk) begin : write_side
    logic [31:0] waddr;
    logic [31:0] word;
    if (i_rst) begin
      o_bvalid <= 1'b0;
      w_beat = 0;
    end else begin
      o_bvalid <= 1'b0;
      if (i_awvalid && o_awready) begin
        aw_addr = i_awaddr;
        w_beat  = 0;
      end
      if (i_wvalid && o_wready) begin
        waddr = aw_addr + 32'(4 * w_beat);
        word  = read_word(waddr);
        for (int b = 0; b < 4; b++) begin
          if (i_wstrb[b]) word[8*b +: 8] = i_wdata[8*b +: 8];
        end
        mem[waddr] = word;
        w_beat++;
        if (i_wlast) o_bvalid <= 1'b1;
      end
    end
  end

endmodule

// ==== sim/tb_axi_bridge.sv ====
`timescale 1ns/1ns

module tb_axi_bridge;
  import mem_bridge_pkg::*;

  localparam int WBUF_DEPTH = 4;
  // reads and writes issued over all tests
  localparam int N_REQ = 1 + 2 + 4 + (WBUF_DEPTH + 3) + WBUF_DEPTH;

  logic aclk, i_rst;
  logic i_inst_rd_req, i_data_rd_req, i_data_wr_req, aw_hold;
  rd_type_t i_inst_rd_type, i_data_rd_type;
  wr_type_t i_data_wr_type;
  logic [31:0] i_inst_rd_addr, i_data_rd_addr, i_data_wr_addr;
  strb_t i_data_wr_strb;
  logic [LINE_W-1:0] i_data_wr_data;
  logic o_inst_rd_rdy, o_inst_ret_valid, o_inst_ret_last;
  logic o_data_rd_rdy, o_data_ret_valid, o_data_ret_last, o_data_wr_rdy;
  logic [31:0] o_inst_ret_data, o_data_ret_data;
  axi_id_t o_arid, i_rid, o_awid;
  logic [31:0] o_araddr, i_rdata, o_awaddr, o_wdata;
  logic [7:0] o_arlen, o_awlen;
  logic o_arvalid, i_arready, i_rlast, i_rvalid, o_awvalid, i_awready;
  strb_t o_wstrb;
  logic o_wlast, o_wvalid, i_wready, i_bvalid;
  logic [31:0] o_inst_reads, o_data_reads, o_data_writes;

  int errors, checks, inst_acc, data_acc, wr_acc, w_seen;
  logic [31:0] shadow [logic [31:0]];
  logic [31:0] exp_inst_q [$];
  logic [31:0] exp_data_q [$];
  wr_type_t wq_type [$];
  logic [31:0] wq_addr [$];
  strb_t wq_strb [$];
  logic [LINE_W-1:0] wq_data [$];

  axi_bridge_top #(.WBUF_DEPTH(WBUF_DEPTH), .CNT_W(32)) axi_bridge_top_inst (.*);

  axi_slave_model slave_inst (
    .aclk(aclk), .i_rst(i_rst), .i_aw_hold(aw_hold),
    .i_arid(o_arid), .i_araddr(o_araddr), .i_arlen(o_arlen), .i_arvalid(o_arvalid),
    .o_arready(i_arready), .o_rid(i_rid), .o_rdata(i_rdata), .o_rlast(i_rlast),
    .o_rvalid(i_rvalid), .i_awaddr(o_awaddr), .i_awvalid(o_awvalid),
    .o_awready(i_awready), .i_wdata(o_wdata), .i_wstrb(o_wstrb), .i_wlast(o_wlast),
    .i_wvalid(o_wvalid), .o_wready(i_wready), .o_bvalid(i_bvalid)
  );

  task automatic expect_true(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] a);
    if (shadow.exists(a)) return shadow[a];
    return a ^ 32'h5a5a0000;
  endfunction

  task automatic store_write(input wr_type_t t, input logic [31:0] a, input strb_t s,
                             input logic [LINE_W-1:0] d);
    logic [31:0] w;
    if (t == TYPE_LINE) begin
      for (int k = 0; k < LINE_WORDS; k++) shadow[a + 32'(4 * k)] = d[32*k +: 32];
    end else begin
      w = model_word(a);
      for (int b = 0; b < 4; b++) if (s[b]) w[8*b +: 8] = d[8*b +: 8];
      shadow[a] = w;
    end
  endtask

  task automatic queue_read(input bit data_port, input rd_type_t t, input logic [31:0] a);
    int n;
    n = (t == TYPE_LINE) ? LINE_WORDS : 1;
    for (int k = 0; k < n; k++) begin
      if (data_port) exp_data_q.push_back(model_word(a + 32'(4 * k)));
      else exp_inst_q.push_back(model_word(a + 32'(4 * k)));
    end
  endtask

  always @(posedge aclk) begin : monitor
    if (!i_rst) begin
      if (o_arvalid && o_arlen == 8'd0)
        expect_true(wq_type.size() == 0, "uncached read on AR while writes lack B");
      expect_true(o_inst_ret_valid == (i_rvalid && i_rid == ID_INST), "inst routing by id");
      expect_true(o_data_ret_valid == (i_rvalid && i_rid == ID_DATA), "data routing by id");
      if (o_inst_ret_valid) begin
        if (exp_inst_q.size() == 0) begin
          errors++;
          $display("unexpected beat on the instruction port at %0t", $time);
        end else begin
          expect_true(o_inst_ret_data == exp_inst_q[0], "instruction return data");
          expect_true(o_inst_ret_last == (exp_inst_q.size() == 1), "instruction ret_last");
          void'(exp_inst_q.pop_front());
        end
      end
      if (o_data_ret_valid) begin
        if (exp_data_q.size() == 0) begin
          errors++;
          $display("unexpected beat on the data port at %0t", $time);
        end else begin
          expect_true(o_data_ret_data == exp_data_q[0], "data return data");
          expect_true(o_data_ret_last == (exp_data_q.size() == 1), "data ret_last");
          void'(exp_data_q.pop_front());
        end
      end
      if (i_inst_rd_req && o_inst_rd_rdy) begin
        inst_acc++;
        expect_true(o_arid == ID_INST && o_araddr == i_inst_rd_addr,
                    "instruction AR id and address");
        expect_true(o_arlen == ((i_inst_rd_type == TYPE_LINE) ? 8'd3 : 8'd0),
                    "instruction AR burst length");
        queue_read(1'b0, i_inst_rd_type, i_inst_rd_addr);
      end
      if (i_data_rd_req && o_data_rd_rdy) begin
        data_acc++;
        expect_true(o_arid == ID_DATA && o_araddr == i_data_rd_addr,
                    "data AR id and address");
        expect_true(o_arlen == ((i_data_rd_type == TYPE_LINE) ? 8'd3 : 8'd0),
                    "data AR burst length");
        queue_read(1'b1, i_data_rd_type, i_data_rd_addr);
      end
      if (o_awvalid && i_awready) begin
        expect_true(o_awid == ID_DATA && o_awaddr == wq_addr[0], "AW id and address");
        expect_true(o_awlen == ((wq_type[0] == TYPE_LINE) ? 8'd3 : 8'd0), "AW burst length");
        w_seen = 0;
      end
      if (o_wvalid && i_wready) begin
        expect_true(o_wdata == wq_data[0][32*w_seen +: 32], "W beat data");
        expect_true(o_wstrb == ((wq_type[0] == TYPE_LINE) ? 4'hf : wq_strb[0]), "W strobe");
        expect_true(o_wlast == (w_seen == ((wq_type[0] == TYPE_LINE) ? LINE_WORDS - 1 : 0)),
                    "wlast on final beat only");
        w_seen++;
      end
      if (i_bvalid && wq_type.size() != 0) begin
        expect_true(w_seen == ((wq_type[0] == TYPE_LINE) ? LINE_WORDS : 1), "W beat count");
        void'(wq_type.pop_front());
        void'(wq_addr.pop_front());
        void'(wq_strb.pop_front());
        void'(wq_data.pop_front());
      end
      if (i_data_wr_req && o_data_wr_rdy) begin
        wr_acc++;
        wq_type.push_back(i_data_wr_type);
        wq_addr.push_back(i_data_wr_addr);
        wq_strb.push_back(i_data_wr_strb);
        wq_data.push_back(i_data_wr_data);
        store_write(i_data_wr_type, i_data_wr_addr, i_data_wr_strb, i_data_wr_data);
      end
    end
  end

  task automatic read_req(input bit data_port, input rd_type_t t, input logic [31:0] a);
    @(negedge aclk);
    if (data_port) begin
      i_data_rd_req = 1'b1;
      i_data_rd_type = t;
      i_data_rd_addr = a;
    end else begin
      i_inst_rd_req = 1'b1;
      i_inst_rd_type = t;
      i_inst_rd_addr = a;
    end
    do @(posedge aclk); while (!(data_port ? o_data_rd_rdy : o_inst_rd_rdy));
    @(negedge aclk);
    if (data_port) i_data_rd_req = 1'b0;
    else i_inst_rd_req = 1'b0;
    while ((data_port ? exp_data_q.size() : exp_inst_q.size()) != 0) @(negedge aclk);
  endtask

  task automatic write_req(input wr_type_t t, input logic [31:0] a, input strb_t s,
                           input logic [LINE_W-1:0] d);
    @(negedge aclk);
    i_data_wr_req = 1'b1;
    i_data_wr_type = t;
    i_data_wr_addr = a;
    i_data_wr_strb = s;
    i_data_wr_data = d;
    do @(posedge aclk); while (!o_data_wr_rdy);
    @(negedge aclk);
    i_data_wr_req = 1'b0;
  endtask

  task automatic drain_writes();
    while (wq_type.size() != 0) @(negedge aclk);
  endtask

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  initial begin
    repeat (200 * N_REQ) @(posedge aclk);
    $display("timeout: the tests did not finish within %0d cycles", 200 * N_REQ);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int tries;
    int got;
    void'($urandom(32'h2e51f739));
    {i_inst_rd_req, i_data_rd_req, i_data_wr_req, aw_hold} = '0;
    {i_inst_rd_type, i_data_rd_type, i_data_wr_type} = '0;
    {i_inst_rd_addr, i_data_rd_addr, i_data_wr_addr} = '0;
    i_data_wr_strb = '0;
    i_data_wr_data = '0;
    i_rst = 1'b1;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    i_rst = 1'b0;
    @(negedge aclk);
    expect_true(!o_arvalid && !o_awvalid && !o_wvalid && o_data_wr_rdy, "idle after reset");
    expect_true(!o_inst_rd_rdy && !o_data_rd_rdy && !o_inst_ret_valid && !o_data_ret_valid,
                "read ports quiet after reset");
    expect_true(o_inst_reads == 0 && o_data_reads == 0 && o_data_writes == 0, "counters zero");

    // line refill, then both ports at once
    read_req(1'b0, TYPE_LINE, 32'h0000_1000);
    fork
      read_req(1'b0, TYPE_LINE, 32'h0000_1040);
      read_req(1'b1, TYPE_LINE, 32'h0000_1080);
    join

    // word and line writes, then an uncached read behind them
    write_req(TYPE_WORD, 32'h0000_3004, 4'b0110, LINE_W'(32'hdeadbeef));
    write_req(TYPE_LINE, 32'h0000_3010, 4'b0001, {32'h44, 32'h33, 32'h22, 32'h11});
    read_req(1'b1, TYPE_WORD, 32'h0000_3004);
    read_req(1'b1, TYPE_WORD, 32'h0000_3018);
    drain_writes();

    // fill the buffer with AW parked
    @(negedge aclk);
    aw_hold = 1'b1;
    got = 0;
    for (tries = 0; tries < WBUF_DEPTH + 3; tries++) begin
      @(negedge aclk);
      i_data_wr_req = 1'b1;
      i_data_wr_type = got[0] ? TYPE_LINE : TYPE_WORD;
      i_data_wr_addr = 32'h0000_4000 + 32'(got * 16);
      i_data_wr_strb = 4'hf;
      i_data_wr_data = {$urandom, $urandom, $urandom, $urandom};
      @(posedge aclk);
      if (o_data_wr_rdy) got++;
    end
    @(negedge aclk);
    expect_true(!o_data_wr_rdy, "write rdy low with a full buffer");
    expect_true(got == WBUF_DEPTH, "writes accepted before the buffer filled");
    i_data_wr_req = 1'b0;
    aw_hold = 1'b0;
    drain_writes();
    for (int i = 0; i < WBUF_DEPTH; i++) begin
      read_req(1'b1, i[0] ? TYPE_LINE : TYPE_WORD, 32'h0000_4000 + 32'(i * 16));
    end

    repeat (5) @(negedge aclk);
    expect_true(o_inst_reads == 32'(inst_acc), "instruction read counter");
    expect_true(o_data_reads == 32'(data_acc), "data read counter");
    expect_true(o_data_writes == 32'(wr_acc), "data write counter");
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
